// File: hdl/pwr_seq_pkg.sv
// Rail sequencing definitions shared by the power controller modules.
// Covers the rail count and vector type, the CPU-B rail mask, the settle and
// timeout constants and the sequencer state encoding.
package pwr_seq_pkg;

	// Number of logical supply rails under sequencer control
	localparam int RAIL_COUNT = 15;

	// One bit per rail, used for enables, power goods, settle flags and fail detail
	typedef logic [RAIL_COUNT-1:0] rail_vec_t;

	// Rails owned by the second CPU: 3, 6, 8, 10, 12 and 14
	localparam rail_vec_t CPUB_RAIL_MASK = 15'h5548;

	// Shared settle/timeout counter, wide enough for the timeout
	typedef logic [7:0] seq_count_t;

	// Cycles a power good must hold before the next rail is enabled
	localparam seq_count_t SETTLE_CYCLES = 8'd16;

	// Cycles an enabled rail may lack power good before a wait fault
	localparam seq_count_t PG_TIMEOUT_CYCLES = 8'd64;

	// What the shared counter is doing
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_SETTLE,
		SEQ_WAIT_PG,
		SEQ_HALT
	} seq_state_t;

endpackage

// File: hdl/pwr_regs_pkg.sv
// Host register map of the power controller.
// Register byte and address types, register addresses and the ID constants
// returned by the version and vendor registers.
package pwr_regs_pkg;

	typedef logic [7:0] reg_data_t;
	typedef logic [7:0] reg_addr_t;

	localparam reg_addr_t REG_VERSION    = 8'h00;
	localparam reg_addr_t REG_CLR_ERR    = 8'h03;
	localparam reg_addr_t REG_STATUS     = 8'h07;
	localparam reg_addr_t REG_EN_LO      = 8'h08;
	localparam reg_addr_t REG_EN_HI      = 8'h09;
	localparam reg_addr_t REG_PG_LO      = 8'h0A;
	localparam reg_addr_t REG_PG_HI      = 8'h0B;
	localparam reg_addr_t REG_VENDOR_ID0 = 8'h0C;
	localparam reg_addr_t REG_VENDOR_ID1 = 8'h0D;
	localparam reg_addr_t REG_VENDOR_ID2 = 8'h0E;
	localparam reg_addr_t REG_VENDOR_ID3 = 8'h0F;
	localparam reg_addr_t REG_FAIL_LO    = 8'h18;
	localparam reg_addr_t REG_FAIL_HI    = 8'h19;

	localparam reg_data_t FPGA_VERSION = 8'h06;

	// Vendor ID bytes, index 0 is read at REG_VENDOR_ID0
	localparam reg_data_t [0:3] VENDOR_ID = {8'h52, 8'h43, 8'h53, 8'h20};

endpackage

// File: hdl/rail_io_map.sv
// Pin-side conditioning for the rail sequencer.
// Synchronizes system enable and the rail power goods, applies the debug
// override, and gates the CPU-B rails when the second CPU is absent.
`timescale 1ns/1ps

module rail_io_map (
	input  logic                   clk_in,
	input  logic                   rst_n,
	input  logic                   sysen,
	input  logic                   debug_in,
	input  logic                   cpub_present_n,
	input  pwr_seq_pkg::rail_vec_t rail_pg,
	input  pwr_seq_pkg::rail_vec_t seq_en,
	output logic                   sys_enable,
	output pwr_seq_pkg::rail_vec_t pg_sync,
	output pwr_seq_pkg::rail_vec_t rail_en,
	output logic                   cpub_clk_oe
);
	import pwr_seq_pkg::*;

	rail_vec_t cpub_off;
	rail_vec_t pg_masked;
	rail_vec_t pg_meta;
	logic      sysen_req;
	logic      sysen_meta;

	// CPU-B rails that must stay dark when the second CPU is missing
	assign cpub_off = CPUB_RAIL_MASK & {RAIL_COUNT{cpub_present_n}};

	// Debug jumper pulled low forces the supplies on
	assign sysen_req = sysen | ~debug_in;

	// Absent CPU-B rails report good once the sequencer asks for them
	assign pg_masked = rail_pg | (cpub_off & seq_en);

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			sysen_meta <= 1'b0;
			sys_enable <= 1'b0;
			pg_meta    <= '0;
			pg_sync    <= '0;
		end else begin
			sysen_meta <= sysen_req;
			sys_enable <= sysen_meta;
			pg_meta    <= pg_masked;
			pg_sync    <= pg_meta;
		end
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			rail_en     <= '0;
			cpub_clk_oe <= 1'b0;
		end else begin
			rail_en     <= seq_en & ~cpub_off;
			cpub_clk_oe <= ~cpub_present_n;
		end
	end

	// Nothing on the CPU-B side may be powered without the CPU fitted
	a_cpub_gated: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		cpub_present_n |-> ((rail_en & CPUB_RAIL_MASK) == '0)
	) else $error("CPU-B rail enabled while CPU B is absent");

endmodule

// File: hdl/rail_sequencer.sv
// Rail enable chain with one shared settle/timeout counter.
// Each rail is enabled after the previous one has held power good for the
// settle delay; shutdown runs top down, keeping a rail on while the one
// above still reports good. Also flags power-good timeouts and drives sysgood.
`timescale 1ns/1ps

module rail_sequencer (
	input  logic                   clk_in,
	input  logic                   rst_n,
	input  logic                   sys_enable,
	input  pwr_seq_pkg::rail_vec_t pg_sync,
	input  logic                   fault,
	output pwr_seq_pkg::rail_vec_t seq_en,
	output pwr_seq_pkg::rail_vec_t settled,
	output logic                   sysgood,
	output logic                   wait_expired
);
	import pwr_seq_pkg::*;

	seq_state_t state;
	seq_state_t mode;
	seq_count_t count;
	seq_count_t cnt_eff;
	rail_vec_t  en_next;
	rail_vec_t  settle_req;
	rail_vec_t  settle_pick;
	rail_vec_t  wait_req;
	logic       settle_done;

	// Rails up with power good but not yet settled, lowest one wins
	assign settle_req  = seq_en & pg_sync & ~settled;
	assign settle_pick = settle_req & (~settle_req + 1'b1);
	assign wait_req    = seq_en & ~pg_sync;

	always_comb begin
		mode = SEQ_IDLE;
		if (fault) begin
			mode = SEQ_HALT;
		end else if (sys_enable && (settle_req != '0)) begin
			mode = SEQ_SETTLE;
		end else if (sys_enable && (wait_req != '0)) begin
			mode = SEQ_WAIT_PG;
		end
	end

	// Count starts over whenever the counter switches job
	assign cnt_eff      = (state == mode) ? count : '0;
	assign settle_done  = (mode == SEQ_SETTLE) && (cnt_eff == SETTLE_CYCLES - 1'b1);
	assign wait_expired = (mode == SEQ_WAIT_PG) && (cnt_eff == PG_TIMEOUT_CYCLES);

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			count <= '0;
		end else begin
			case (mode)
				SEQ_SETTLE: begin
					if (settle_done) begin
						state <= SEQ_IDLE;
						count <= '0;
					end else begin
						state <= SEQ_SETTLE;
						count <= cnt_eff + 1'b1;
					end
				end
				SEQ_WAIT_PG: begin
					state <= SEQ_WAIT_PG;
					count <= wait_expired ? '0 : cnt_eff + 1'b1;
				end
				default: begin
					state <= mode;
					count <= '0;
				end
			endcase
		end
	end

	// Up: previous rail settled. Down: hold while the rail above is still good
	always_comb begin
		en_next[0] = sys_enable | pg_sync[1];
		for (int i = 1; i < RAIL_COUNT - 1; i++) begin
			en_next[i] = (sys_enable & settled[i-1]) | pg_sync[i+1];
		end
		en_next[RAIL_COUNT-1] = sys_enable & settled[RAIL_COUNT-2];
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			seq_en  <= '0;
			settled <= '0;
			sysgood <= 1'b0;
		end else begin
			seq_en  <= fault ? '0 : en_next;
			sysgood <= settled[RAIL_COUNT-1];
			if (fault || !sys_enable) begin
				settled <= '0;
			end else if (settle_done) begin
				settled <= settled | settle_pick;
			end
		end
	end

	// A latched fault must drop every enable on the next edge
	a_fault_off: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		fault |=> (seq_en == '0)
	) else $error("Enables still on after fault");

endmodule

// File: hdl/fault_monitor.sv
// Fault latch for the rail sequencer.
// Records power-good timeouts and drop-outs of settled rails until the host
// clears them, and keeps a snapshot of the rails that failed.
`timescale 1ns/1ps

module fault_monitor (
	input  logic                   clk_in,
	input  logic                   rst_n,
	input  pwr_seq_pkg::rail_vec_t seq_en,
	input  pwr_seq_pkg::rail_vec_t pg_sync,
	input  pwr_seq_pkg::rail_vec_t settled,
	input  logic                   wait_expired,
	input  logic                   clear_err,
	output logic                   fault,
	output logic                   wait_err,
	output logic                   op_err,
	output pwr_seq_pkg::rail_vec_t fail_detail
);
	import pwr_seq_pkg::*;

	rail_vec_t lost_pg;
	logic      fault_q;

	// Settled rails that have lost their power good
	assign lost_pg = settled & ~pg_sync;
	assign fault   = wait_err | op_err;

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			wait_err <= 1'b0;
			op_err   <= 1'b0;
		end else if (clear_err) begin
			wait_err <= 1'b0;
			op_err   <= 1'b0;
		end else begin
			if (wait_expired) begin
				wait_err <= 1'b1;
			end
			if (lost_pg != '0) begin
				op_err <= 1'b1;
			end
		end
	end

	// Snapshot taken only on the first fault cycle, while rails are still up
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			fault_q     <= 1'b0;
			fail_detail <= '0;
		end else begin
			fault_q <= fault;
			if (fault && !fault_q) begin
				fail_detail <= seq_en ^ pg_sync;
			end
		end
	end

	// Detail must not move once the fault is established
	a_detail_held: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		(fault && fault_q) |=> $stable(fail_detail)
	) else $error("fail_detail changed during fault");

endmodule

// File: hdl/status_regs.sv
// Host-visible register file of the power controller.
// Loading an address selects a register, each read strobe steps to the
// next one, and reg_rdata follows one cycle after the address moves.
// Selecting the clear-error address pulses clear_err.
`timescale 1ns/1ps

module status_regs (
	input  logic                    clk_in,
	input  logic                    rst_n,
	input  pwr_regs_pkg::reg_addr_t reg_addr,
	input  logic                    reg_addr_valid,
	input  logic                    reg_rd_next,
	input  logic                    cpub_present_n,
	input  logic                    sys_enable,
	input  logic                    sysgood,
	input  logic                    fault,
	input  logic                    wait_err,
	input  logic                    op_err,
	input  pwr_seq_pkg::rail_vec_t  seq_en,
	input  pwr_seq_pkg::rail_vec_t  pg_sync,
	input  pwr_seq_pkg::rail_vec_t  fail_detail,
	output logic                    clear_err,
	output pwr_regs_pkg::reg_data_t reg_rdata
);
	import pwr_seq_pkg::*;
	import pwr_regs_pkg::*;

	reg_addr_t cur_addr;
	reg_data_t status_byte;
	reg_data_t rd_mux;

	function automatic reg_data_t lo_byte(input rail_vec_t v);
		return v[7:0];
	endfunction

	// Upper rails, padded with zeros at the top
	function automatic reg_data_t hi_byte(input rail_vec_t v);
		return {{(16 - RAIL_COUNT){1'b0}}, v[RAIL_COUNT-1:8]};
	endfunction

	assign status_byte = {2'b00, ~cpub_present_n, wait_err, op_err, fault, sys_enable, sysgood};

	always_comb begin
		case (cur_addr)
			REG_VERSION:    rd_mux = FPGA_VERSION;
			REG_CLR_ERR:    rd_mux = 8'hFF;
			REG_STATUS:     rd_mux = status_byte;
			REG_EN_LO:      rd_mux = lo_byte(seq_en);
			REG_EN_HI:      rd_mux = hi_byte(seq_en);
			REG_PG_LO:      rd_mux = lo_byte(pg_sync);
			REG_PG_HI:      rd_mux = hi_byte(pg_sync);
			REG_VENDOR_ID0: rd_mux = VENDOR_ID[0];
			REG_VENDOR_ID1: rd_mux = VENDOR_ID[1];
			REG_VENDOR_ID2: rd_mux = VENDOR_ID[2];
			REG_VENDOR_ID3: rd_mux = VENDOR_ID[3];
			REG_FAIL_LO:    rd_mux = lo_byte(fail_detail);
			REG_FAIL_HI:    rd_mux = hi_byte(fail_detail);
			default:        rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			cur_addr  <= '0;
			clear_err <= 1'b0;
			reg_rdata <= '0;
		end else begin
			clear_err <= reg_addr_valid && (reg_addr == REG_CLR_ERR);
			if (reg_addr_valid) begin
				cur_addr <= reg_addr;
			end else if (reg_rd_next) begin
				cur_addr <= cur_addr + 1'b1;
			end
			reg_rdata <= rd_mux;
		end
	end

endmodule

// File: hdl/power_ctrl_top.sv
// Top level of the rail power controller.
// Pin conditioning feeds the sequencer and fault latch; the register block
// reports their state to the host over the parallel register port.
`timescale 1ns/1ps

module power_ctrl_top (
	input  logic                    clk_in,
	input  logic                    rst_n,
	input  logic                    sysen,
	input  logic                    debug_in,
	input  logic                    cpub_present_n,
	input  pwr_seq_pkg::rail_vec_t  rail_pg,
	input  pwr_regs_pkg::reg_addr_t reg_addr,
	input  logic                    reg_addr_valid,
	input  logic                    reg_rd_next,
	output pwr_seq_pkg::rail_vec_t  rail_en,
	output logic                    sysgood,
	output logic                    cpub_clk_oe,
	output pwr_regs_pkg::reg_data_t reg_rdata
);
	import pwr_seq_pkg::*;

	rail_vec_t pg_sync;
	rail_vec_t seq_en;
	rail_vec_t settled;
	rail_vec_t fail_detail;
	logic      sys_enable;
	logic      wait_expired;
	logic      fault;
	logic      wait_err;
	logic      op_err;
	logic      clear_err;

	rail_io_map u_io (
		.clk_in         (clk_in),
		.rst_n          (rst_n),
		.sysen          (sysen),
		.debug_in       (debug_in),
		.cpub_present_n (cpub_present_n),
		.rail_pg        (rail_pg),
		.seq_en         (seq_en),
		.sys_enable     (sys_enable),
		.pg_sync        (pg_sync),
		.rail_en        (rail_en),
		.cpub_clk_oe    (cpub_clk_oe)
	);

	rail_sequencer u_seq (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.sys_enable   (sys_enable),
		.pg_sync      (pg_sync),
		.fault        (fault),
		.seq_en       (seq_en),
		.settled      (settled),
		.sysgood      (sysgood),
		.wait_expired (wait_expired)
	);

	fault_monitor u_fault (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.seq_en       (seq_en),
		.pg_sync      (pg_sync),
		.settled      (settled),
		.wait_expired (wait_expired),
		.clear_err    (clear_err),
		.fault        (fault),
		.wait_err     (wait_err),
		.op_err       (op_err),
		.fail_detail  (fail_detail)
	);

	status_regs u_regs (
		.clk_in         (clk_in),
		.rst_n          (rst_n),
		.reg_addr       (reg_addr),
		.reg_addr_valid (reg_addr_valid),
		.reg_rd_next    (reg_rd_next),
		.cpub_present_n (cpub_present_n),
		.sys_enable     (sys_enable),
		.sysgood        (sysgood),
		.fault          (fault),
		.wait_err       (wait_err),
		.op_err         (op_err),
		.seq_en         (seq_en),
		.pg_sync        (pg_sync),
		.fail_detail    (fail_detail),
		.clear_err      (clear_err),
		.reg_rdata      (reg_rdata)
	);

endmodule

// File: test/power_ctrl_checker.sv
// Checker for the power controller testbench.
// Watches the DUT pins every clock, compares enables, system good and the
// CPU-B clock enable with reference rules, and compares register reads on request.
`timescale 1ns/1ps

module power_ctrl_checker (
	input  logic                   clk_in,
	input  logic                   rst_n,
	input  logic                   cpub_present_n,
	input  pwr_seq_pkg::rail_vec_t rail_pg,
	input  pwr_seq_pkg::rail_vec_t rail_en,
	input  logic                   sysgood,
	input  logic                   cpub_clk_oe,
	input  logic                   check_down,
	output int                     errors
);
	import pwr_seq_pkg::*;
	import pwr_regs_pkg::*;

	rail_vec_t prev_en;
	rail_vec_t rose;
	rail_vec_t fell;
	rail_vec_t allowed;
	int        pg_cnt [RAIL_COUNT];
	int        run_cycles;
	logic      prev_present_n;

	// Rails that may be driven: CPU-B rails 3, 6, 8, 10, 12, 14 drop out when absent
	function automatic rail_vec_t expected_enables(input logic absent_n);
		return absent_n ? 15'h2AB7 : 15'h7FFF;
	endfunction

	// A timeout on one rail leaves exactly that rail enabled without power good
	function automatic rail_vec_t expected_fail(input int rail);
		return rail_vec_t'(1) << rail;
	endfunction

	function automatic reg_data_t expected_reg(input reg_addr_t addr, input reg_data_t status,
		input rail_vec_t en, input rail_vec_t pg, input rail_vec_t fail);
		case (addr)
			8'h00:   return 8'h06;
			8'h03:   return 8'hFF;
			8'h07:   return status;
			8'h08:   return en[7:0];
			8'h09:   return {1'b0, en[14:8]};
			8'h0A:   return pg[7:0];
			8'h0B:   return {1'b0, pg[14:8]};
			8'h0C:   return 8'h52;
			8'h0D:   return 8'h43;
			8'h0E:   return 8'h53;
			8'h0F:   return 8'h20;
			8'h18:   return fail[7:0];
			8'h19:   return {1'b0, fail[14:8]};
			default: return 8'h00;
		endcase
	endfunction

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Register reads are compared against the pins as seen right now
	task automatic check_reg(input string name, input reg_addr_t addr, input reg_data_t status,
		input rail_vec_t fail, input reg_data_t mask, input reg_data_t act);
		compare(name, 16'(expected_reg(addr, status, rail_en, rail_pg, fail) & mask),
			16'(act & mask));
	endtask

	initial begin
		errors = 0;
	end

	always @(posedge clk_in) begin
		if (!rst_n) begin
			run_cycles     = 0;
			prev_en        = '0;
			prev_present_n = cpub_present_n;
			for (int i = 0; i < RAIL_COUNT; i++) begin
				pg_cnt[i] = 0;
			end
		end else begin
			allowed = expected_enables(cpub_present_n);
			rose    = rail_en & ~prev_en;
			fell    = ~rail_en & prev_en;
			compare("gated enables", 16'(rail_en & allowed), 16'(rail_en));
			if (sysgood) begin
				compare("enables at sysgood", 16'(allowed), 16'(rail_en));
			end
			if ($countones(rose) > 1) begin
				$display("More than one rail was enabled in the same cycle");
				errors++;
			end
			for (int i = 1; i < RAIL_COUNT; i++) begin
				if (rose[i] && allowed[i-1] &&
					(!prev_en[i-1] || pg_cnt[i-1] < int'(SETTLE_CYCLES))) begin
					$display("Rail %0d was enabled before rail %0d had settled", i, i - 1);
					errors++;
				end
			end
			if (check_down) begin
				for (int i = 0; i < RAIL_COUNT - 1; i++) begin
					if (fell[i] && prev_en[i+1]) begin
						$display("Rail %0d turned off before rail %0d", i, i + 1);
						errors++;
					end
				end
			end
			if (run_cycles >= 2) begin
				compare("cpub_clk_oe", 16'(!prev_present_n), 16'(cpub_clk_oe));
			end
			for (int i = 0; i < RAIL_COUNT; i++) begin
				pg_cnt[i] = rail_pg[i] ? pg_cnt[i] + 1 : 0;
			end
			run_cycles++;
			prev_present_n = cpub_present_n;
			prev_en        = rail_en;
		end
	end

endmodule

// File: test/tb_power_ctrl.sv
// Testbench for the rail power controller.
// Models the rail supplies, runs the power-up, fault, register and shutdown
// tests, and prints one line per test and a closing count line.
`timescale 1ns/1ps

module tb_power_ctrl;
	import pwr_seq_pkg::*;
	import pwr_regs_pkg::*;

	logic      clk_in;
	logic      rst_n;
	logic      sysen;
	logic      debug_in;
	logic      cpub_present_n;
	rail_vec_t rail_pg;
	reg_addr_t reg_addr;
	logic      reg_addr_valid;
	logic      reg_rd_next;
	rail_vec_t rail_en;
	logic      sysgood;
	logic      cpub_clk_oe;
	reg_data_t reg_rdata;
	logic      check_down;
	logic      timed_out;
	int        errors;
	int        seed;
	int        held_rail;
	int        rise_cnt [RAIL_COUNT];
	int        tests_run;
	int        tests_failed;
	int        start_errors;
	reg_data_t rd;

	power_ctrl_top UUT (
		.clk_in(clk_in), .rst_n(rst_n), .sysen(sysen), .debug_in(debug_in),
		.cpub_present_n(cpub_present_n), .rail_pg(rail_pg), .reg_addr(reg_addr),
		.reg_addr_valid(reg_addr_valid), .reg_rd_next(reg_rd_next), .rail_en(rail_en),
		.sysgood(sysgood), .cpub_clk_oe(cpub_clk_oe), .reg_rdata(reg_rdata)
	);

	power_ctrl_checker u_checker (
		.clk_in(clk_in), .rst_n(rst_n), .cpub_present_n(cpub_present_n),
		.rail_pg(rail_pg), .rail_en(rail_en), .sysgood(sysgood),
		.cpub_clk_oe(cpub_clk_oe), .check_down(check_down), .errors(errors)
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	// Supply model: good 3 to 10 cycles after enable, drops once enable is gone
	always @(posedge clk_in) begin
		#1;
		for (int i = 0; i < RAIL_COUNT; i++) begin
			if (!rail_en[i]) begin
				rise_cnt[i] = 0;
				rail_pg[i]  = 1'b0;
			end else if (!rail_pg[i] && i != held_rail) begin
				if (rise_cnt[i] == 0) begin
					rise_cnt[i] = 3 + ($unsigned($random(seed)) % 8);
				end else begin
					rise_cnt[i]--;
					if (rise_cnt[i] == 0) rail_pg[i] = 1'b1;
				end
			end
		end
	end

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		timed_out = 1'b1;
	endtask

	task automatic reset_dut(input logic absent_n);
		@(posedge clk_in);
		#1;
		rst_n          = 1'b0;
		cpub_present_n = absent_n;
		repeat (8) @(posedge clk_in);
		#1 rst_n = 1'b1;
	endtask

	task automatic wait_sysgood(input logic level);
		int n;
		n = 0;
		while (sysgood !== level && !timed_out) begin
			@(posedge clk_in);
			n++;
			if (n > 3000) report_timeout("sysgood");
		end
	endtask

	task automatic wait_rail_on(input int rail);
		int n;
		n = 0;
		while (rail_en[rail] !== 1'b1 && !timed_out) begin
			@(posedge clk_in);
			n++;
			if (n > 2000) report_timeout("a rail enable");
		end
	endtask

	task automatic wait_all_off();
		int n;
		n = 0;
		while (rail_en !== '0 && !timed_out) begin
			@(posedge clk_in);
			n++;
			if (n > 2000) report_timeout("all enables to drop");
		end
	endtask

	task automatic read_at(input reg_addr_t addr, output reg_data_t data);
		@(posedge clk_in);
		#1 reg_addr = addr;
		reg_addr_valid = 1'b1;
		@(posedge clk_in);
		#1 reg_addr_valid = 1'b0;
		@(posedge clk_in);
		#1 data = reg_rdata;
	endtask

	task automatic read_next(output reg_data_t data);
		@(posedge clk_in);
		#1 reg_rd_next = 1'b1;
		@(posedge clk_in);
		#1 reg_rd_next = 1'b0;
		@(posedge clk_in);
		#1 data = reg_rdata;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != start_errors || timed_out) begin
			tests_failed++;
			$display("%-24s FAIL", name);
		end else begin
			$display("%-24s ok", name);
		end
		start_errors = errors;
	endtask

	initial begin
		seed = 32'hcb05;
		rst_n = 1'b0;
		sysen = 1'b1;
		debug_in = 1'b1;
		cpub_present_n = 1'b0;
		rail_pg = '0;
		reg_addr = '0;
		reg_addr_valid = 1'b0;
		reg_rd_next = 1'b0;
		check_down = 1'b0;
		timed_out = 1'b0;
		held_rail = -1;
		tests_run = 0;
		tests_failed = 0;
		start_errors = 0;

		reset_dut(1'b0);
		wait_sysgood(1'b1);
		end_test("power-up");

		reset_dut(1'b1);
		wait_sysgood(1'b1);
		u_checker.compare("cpub_clk_oe absent", 16'h0, 16'(cpub_clk_oe));
		end_test("cpu-b absent");

		held_rail = 5;
		reset_dut(1'b0);
		wait_rail_on(5);
		wait_all_off();
		read_at(REG_STATUS, rd);
		u_checker.check_reg("status after timeout", REG_STATUS, 8'h36, '0, 8'hFF, rd);
		read_at(REG_FAIL_LO, rd);
		u_checker.check_reg("fail lo", REG_FAIL_LO, 8'h00, u_checker.expected_fail(5), 8'hFF, rd);
		read_at(REG_FAIL_HI, rd);
		u_checker.check_reg("fail hi", REG_FAIL_HI, 8'h00, u_checker.expected_fail(5), 8'hFF, rd);
		end_test("pg timeout");

		held_rail = -1;
		read_at(REG_CLR_ERR, rd);
		u_checker.check_reg("clear-error read", REG_CLR_ERR, 8'h00, '0, 8'hFF, rd);
		read_at(REG_STATUS, rd);
		// Sysgood may still be on its way, so only fault and enable bits count
		u_checker.check_reg("status after clear", REG_STATUS, 8'h22, '0, 8'h3E, rd);
		wait_sysgood(1'b1);
		end_test("clear and retry");

		read_at(REG_VERSION, rd);
		u_checker.check_reg("reg 0x00", REG_VERSION, 8'h23, '0, 8'hFF, rd);
		for (int a = 1; a <= 15; a++) begin
			read_next(rd);
			u_checker.check_reg($sformatf("reg 0x%02h", a), reg_addr_t'(a), 8'h23,
				u_checker.expected_fail(5), 8'hFF, rd);
		end
		end_test("register map");

		check_down = 1'b1;
		@(posedge clk_in);
		#1 sysen = 1'b0;
		wait_sysgood(1'b0);
		wait_all_off();
		check_down = 1'b0;
		end_test("shutdown");

		$display("Tests run: %0d, failed: %0d, check errors: %0d", tests_run, tests_failed,
			errors);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: sources.f
hdl/pwr_seq_pkg.sv
hdl/pwr_regs_pkg.sv
hdl/rail_io_map.sv
hdl/rail_sequencer.sv
hdl/fault_monitor.sv
hdl/status_regs.sv
hdl/power_ctrl_top.sv
test/power_ctrl_checker.sv
test/tb_power_ctrl.sv

// File: Makefile
TOP = tb_power_ctrl
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)
	verilator --lint-only hdl/pwr_seq_pkg.sv hdl/pwr_regs_pkg.sv hdl/rail_io_map.sv \
		hdl/rail_sequencer.sv hdl/fault_monitor.sv hdl/status_regs.sv \
		hdl/power_ctrl_top.sv --top-module power_ctrl_top

clean:
	rm -rf obj_dir $(LOG)
